/* logic/core_pkg.sv */
package core_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int XLEN     = 32;
    localparam int ADDR_W   = 32;
    localparam int GPR_ID_W = 5;

    // ============================================================
    // major opcodes and function fields
    // ============================================================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // ============================================================
    // decoded control
    // ============================================================
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    typedef enum logic {OPA_RS1 = 1'b0, OPA_ZERO = 1'b1} op_a_sel_e;
    typedef enum logic {OPB_RS2 = 1'b0, OPB_IMM = 1'b1} op_b_sel_e;
    typedef enum logic {WB_ALU = 1'b0, WB_PC4 = 1'b1} wb_src_e;

    typedef struct packed {
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        wb_src_e   wb_src;
        logic      reg_wr_en;
        logic      illegal;
    } idex_ctrl_t;

    // no write, no side effects
    localparam idex_ctrl_t CTRL_NOP = '{ALU_ADD, OPA_RS1, OPB_RS2, WB_ALU, 1'b0, 1'b0};

endpackage

/* logic/idex_if.sv */
`timescale 1ns/100ps

interface idex_if;
    import core_pkg::*;

    logic                valid;
    logic [ADDR_W-1:0]   pc;
    idex_ctrl_t          ctrl;
    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;
    logic [XLEN-1:0]     imm;
    logic [GPR_ID_W-1:0] rd;

    modport src (
        output valid,
        output pc,
        output ctrl,
        output rs1_data,
        output rs2_data,
        output imm,
        output rd
    );

    modport dst (
        input valid,
        input pc,
        input ctrl,
        input rs1_data,
        input rs2_data,
        input imm,
        input rd
    );

endinterface

/* logic/gpr_file.sv */
`timescale 1ns/100ps

module gpr_file #(
    parameter int GPR_COUNT = 32
) (
    input  logic                               i_sys_clk,
    input  logic                               i_sys_rst_n,
    input  logic [core_pkg::GPR_ID_W-1:0]      i_rs1_id,
    input  logic [core_pkg::GPR_ID_W-1:0]      i_rs2_id,
    output logic [core_pkg::XLEN-1:0]          o_rs1_data,
    output logic [core_pkg::XLEN-1:0]          o_rs2_data,
    input  logic                               i_wr_en,
    input  logic [core_pkg::GPR_ID_W-1:0]      i_wr_id,
    input  logic [core_pkg::XLEN-1:0]          i_wr_data
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [GPR_COUNT];

    // x0 and indices past GPR_COUNT read as zero, a pending write is forwarded
    function automatic logic [XLEN-1:0] read_port(input logic [GPR_ID_W-1:0] id);
        logic [XLEN-1:0] val;
        if (id == '0 || int'(id) >= GPR_COUNT) begin
            val = '0;
        end else if (i_wr_en && id == i_wr_id) begin
            val = i_wr_data;
        end else begin
            val = regs[id];
        end
        return val;
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_id);
        o_rs2_data = read_port(i_rs2_id);
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            for (int i = 0; i < GPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_id != '0 && int'(i_wr_id) < GPR_COUNT) begin
            regs[i_wr_id] <= i_wr_data;
        end
    end

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  logic                          i_inst_valid,
    input  logic [31:0]                   i_inst,
    input  logic [core_pkg::ADDR_W-1:0]   i_pc,
    output logic [core_pkg::GPR_ID_W-1:0] o_rs1_id,
    output logic [core_pkg::GPR_ID_W-1:0] o_rs2_id,
    input  logic [core_pkg::XLEN-1:0]     i_rs1_data,
    input  logic [core_pkg::XLEN-1:0]     i_rs2_data,
    idex_if.src                           o_bus
);
    import core_pkg::*;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [GPR_ID_W-1:0] rd;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_u;
    logic [XLEN-1:0]     imm_j;
    logic [XLEN-1:0]     imm;
    idex_ctrl_t          ctrl;

    // ============================================================
    // field split and immediates
    // ============================================================
    assign opcode   = i_inst[6:0];
    assign rd       = i_inst[11:7];
    assign funct3   = i_inst[14:12];
    assign o_rs1_id = i_inst[19:15];
    assign o_rs2_id = i_inst[24:20];
    assign funct7   = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    // ============================================================
    // control decode
    // ============================================================
    always_comb begin
        ctrl = CTRL_NOP;
        imm  = imm_i;
        case (opcode)
            OPC_OP: begin
                ctrl.reg_wr_en = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: ctrl.alu_op = ALU_ADD;
                    {F7_ALT,  F3_ADD_SUB}: ctrl.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLL}:     ctrl.alu_op = ALU_SLL;
                    {F7_BASE, F3_SLT}:     ctrl.alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}:     ctrl.alu_op = ALU_XOR;
                    {F7_BASE, F3_SRL}:     ctrl.alu_op = ALU_SRL;
                    {F7_BASE, F3_OR}:      ctrl.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:     ctrl.alu_op = ALU_AND;
                    default:               ctrl.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl.op_b_sel  = OPB_IMM;
                ctrl.reg_wr_en = 1'b1;
                case (funct3)
                    F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    ctrl.illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                // zero + upper immediate
                ctrl.op_a_sel  = OPA_ZERO;
                ctrl.op_b_sel  = OPB_IMM;
                ctrl.reg_wr_en = 1'b1;
                imm            = imm_u;
            end
            OPC_JAL: begin
                // link value is pc+4, the offset only rides along
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.op_b_sel  = OPB_IMM;
                ctrl.wb_src    = WB_PC4;
                ctrl.reg_wr_en = 1'b1;
                imm            = imm_j;
            end
            default: ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl.reg_wr_en = 1'b0;
        end
    end

    assign o_bus.valid    = i_inst_valid;
    assign o_bus.pc       = i_pc;
    assign o_bus.ctrl     = ctrl;
    assign o_bus.rs1_data = i_rs1_data;
    assign o_bus.rs2_data = i_rs2_data;
    assign o_bus.imm      = imm;
    assign o_bus.rd       = rd;

endmodule

/* logic/idu2exu.sv */
`timescale 1ns/100ps

module idu2exu #(
    parameter logic [core_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  logic i_sys_clk,
    input  logic i_sys_rst_n,
    idex_if.dst  i_bus,
    idex_if.src  o_bus
);
    import core_pkg::*;

    logic                r_valid;
    logic [ADDR_W-1:0]   r_pc;
    idex_ctrl_t          r_ctrl;
    logic [GPR_ID_W-1:0] r_rd;
    logic [XLEN-1:0]     r_rs1_data;
    logic [XLEN-1:0]     r_rs2_data;
    logic [XLEN-1:0]     r_imm;

    // strobe follows the input every cycle
    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= i_bus.valid;
        end
    end

    // ============================================================
    // control and pc, held between strobes
    // ============================================================
    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            r_pc   <= RESET_PC;
            r_ctrl <= CTRL_NOP;
            r_rd   <= '0;
        end else if (i_bus.valid) begin
            r_pc   <= i_bus.pc;
            r_ctrl <= i_bus.ctrl;
            r_rd   <= i_bus.rd;
        end
    end

    // operand payload
    always_ff @(posedge i_sys_clk) begin
        if (i_bus.valid) begin
            r_rs1_data <= i_bus.rs1_data;
            r_rs2_data <= i_bus.rs2_data;
            r_imm      <= i_bus.imm;
        end
    end

    assign o_bus.valid    = r_valid;
    assign o_bus.pc       = r_pc;
    assign o_bus.ctrl     = r_ctrl;
    assign o_bus.rd       = r_rd;
    assign o_bus.rs1_data = r_rs1_data;
    assign o_bus.rs2_data = r_rs2_data;
    assign o_bus.imm      = r_imm;

endmodule

/* logic/alu_exec.sv */
`timescale 1ns/100ps

module alu_exec (
    input  logic                          i_sys_clk,
    input  logic                          i_sys_rst_n,
    idex_if.dst                           i_bus,
    output logic                          o_wb_valid,
    output logic                          o_wb_wr,
    output logic [core_pkg::GPR_ID_W-1:0] o_wb_rd,
    output logic [core_pkg::XLEN-1:0]     o_wb_data,
    output logic [core_pkg::ADDR_W-1:0]   o_wb_pc
);
    import core_pkg::*;

    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [4:0]        shamt;
    logic [XLEN-1:0]   alu_res;
    logic [ADDR_W-1:0] pc_plus4;
    logic [XLEN-1:0]   wb_val;

    // ============================================================
    // operands and ALU
    // ============================================================
    assign op_a  = (i_bus.ctrl.op_a_sel == OPA_ZERO) ? '0 : i_bus.rs1_data;
    assign op_b  = (i_bus.ctrl.op_b_sel == OPB_IMM) ? i_bus.imm : i_bus.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_bus.ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign pc_plus4 = i_bus.pc + ADDR_W'(4);
    assign wb_val   = (i_bus.ctrl.wb_src == WB_PC4) ? XLEN'(pc_plus4) : alu_res;

    // ============================================================
    // writeback register
    // ============================================================
    // write strobe is a one cycle pulse, x0 never written
    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            o_wb_valid <= 1'b0;
            o_wb_wr    <= 1'b0;
        end else begin
            o_wb_valid <= i_bus.valid;
            o_wb_wr    <= i_bus.valid && i_bus.ctrl.reg_wr_en && (i_bus.rd != '0);
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_bus.valid) begin
            o_wb_rd   <= i_bus.rd;
            o_wb_data <= wb_val;
            o_wb_pc   <= i_bus.pc;
        end
    end

endmodule

/* logic/core_top.sv */
`timescale 1ns/100ps

module core_top #(
    parameter int                          GPR_COUNT = 32,
    parameter logic [core_pkg::ADDR_W-1:0] RESET_PC  = 32'h8000_0000
) (
    input  logic                          i_sys_clk,
    input  logic                          i_sys_rst_n,
    input  logic                          i_inst_valid,
    input  logic [31:0]                   i_inst,
    input  logic [core_pkg::ADDR_W-1:0]   i_pc,
    output logic                          o_wb_valid,
    output logic                          o_wb_wr,
    output logic [core_pkg::GPR_ID_W-1:0] o_wb_rd,
    output logic [core_pkg::XLEN-1:0]     o_wb_data,
    output logic [core_pkg::ADDR_W-1:0]   o_wb_pc
);
    import core_pkg::*;

    logic [GPR_ID_W-1:0] rs1_id;
    logic [GPR_ID_W-1:0] rs2_id;
    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;

    idex_if dec_bus ();
    idex_if exe_bus ();

    // writeback outputs double as the register file write port
    gpr_file #(
        .GPR_COUNT (GPR_COUNT)
    ) u_gpr (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_rs1_id    (rs1_id),
        .i_rs2_id    (rs2_id),
        .o_rs1_data  (rs1_data),
        .o_rs2_data  (rs2_data),
        .i_wr_en     (o_wb_wr),
        .i_wr_id     (o_wb_rd),
        .i_wr_data   (o_wb_data)
    );

    inst_decoder u_dec (
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_rs1_id     (rs1_id),
        .o_rs2_id     (rs2_id),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_bus        (dec_bus.src)
    );

    idu2exu #(
        .RESET_PC (RESET_PC)
    ) u_i2e (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_bus       (dec_bus.dst),
        .o_bus       (exe_bus.src)
    );

    alu_exec u_exe (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst_n (i_sys_rst_n),
        .i_bus       (exe_bus.dst),
        .o_wb_valid  (o_wb_valid),
        .o_wb_wr     (o_wb_wr),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data),
        .o_wb_pc     (o_wb_pc)
    );

endmodule

/* tests/core_props.sv */
`timescale 1ns/100ps

module core_props #(
    parameter bit CHECK_WR = 1'b1
) (
    input logic                          i_sys_clk,
    input logic                          i_sys_rst_n,
    input logic                          i_valid_in,
    input logic                          i_valid_out,
    input logic                          i_wr,
    input logic [core_pkg::GPR_ID_W-1:0] i_rd
);

    // registered strobe is the input strobe one clock later
    a_valid_follows: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        i_valid_out == $past(i_valid_in))
        else $error("valid out does not follow valid in");

    // only the execute stage drives a register write
    if (CHECK_WR) begin : g_wr_check
        a_wr_not_x0: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst_n)
            i_wr |-> i_rd != '0)
            else $error("register write aimed at x0");
    end

    a_idle_after_reset: assert property (@(posedge i_sys_clk)
        $rose(i_sys_rst_n) |-> !i_valid_out)
        else $error("valid high in the first cycle after reset");

endmodule

bind alu_exec core_props u_exe_props (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_valid_in  (i_bus.valid),
    .i_valid_out (o_wb_valid),
    .i_wr        (o_wb_wr),
    .i_rd        (o_wb_rd)
);

bind idu2exu core_props #(
    .CHECK_WR (1'b0)
) u_i2e_props (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst_n (i_sys_rst_n),
    .i_valid_in  (i_bus.valid),
    .i_valid_out (o_bus.valid),
    .i_wr        (1'b0),
    .i_rd        ('0)
);

/* tests/tb_core_top.sv */
`timescale 1ns/100ps

module tb_core_top;

    // the tests need a few hundred cycles
    localparam int CYCLE_LIMIT = 2000;
    localparam int OP_ADD      = 0;
    localparam int OP_SUB      = 1;
    localparam int OP_ADDI     = 8;
    localparam int OP_LUI      = 13;
    localparam int OP_JAL      = 14;
    localparam int OP_BAD_OPC  = 15;
    localparam int OP_BAD_F7   = 16;
    // funct3 per ALU kind with kind 0 in the low bits
    localparam logic [23:0] F3_BY_KIND = {3'b101, 3'b001, 3'b010, 3'b100,
                                          3'b110, 3'b111, 3'b000, 3'b000};

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] data;
        logic [31:0] cyc;
        logic [4:0]  rd;
        logic        wr;
        logic        chk_data;
    } wb_exp_t;

    logic        i_sys_clk;
    logic        i_sys_rst_n;
    logic        i_inst_valid;
    logic [31:0] i_inst;
    logic [31:0] i_pc;
    logic        o_wb_valid;
    logic        o_wb_wr;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic [31:0] o_wb_pc;

    integer      seed;
    int          cycles = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    logic [31:0] cur_pc;
    logic [31:0] shadow [32];
    wb_exp_t     exp_q [$];
    wb_exp_t     got;

    core_top u_dut (.*);

    initial i_sys_clk = 1'b0;
    always #5 i_sys_clk = ~i_sys_clk;

    always @(posedge i_sys_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: a writeback was still missing after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // every writeback must match the oldest issued instruction
    always @(negedge i_sys_clk) begin
        if (i_sys_rst_n && o_wb_valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                $display("writeback at %0t without an issued instruction", $time);
                n_fail++;
            end else begin
                got = exp_q.pop_front();
                check_val(cycles, got.cyc, "writeback cycle");
                check_val(o_wb_pc, got.pc, "writeback pc");
                check_val(32'(o_wb_rd), 32'(got.rd), "writeback rd");
                check_val(32'(o_wb_wr), 32'(got.wr), "write enable");
                if (got.chk_data) begin
                    check_val(o_wb_data, got.data, "writeback data");
                end
            end
        end
    end

    task automatic check_val(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, act, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    // ============================================================
    // encoding and reference model
    // ============================================================
    function automatic logic [31:0] encode(input int op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
        logic [2:0] f3;
        f3 = F3_BY_KIND[3*(op%8) +: 3];
        if (op < OP_ADDI) begin
            return {(op == OP_SUB) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
        end else if (op < OP_LUI) begin
            return {imm[11:0], rs1, f3, rd, 7'b0010011};
        end else if (op == OP_LUI) begin
            return {imm[31:12], rd, 7'b0110111};
        end else if (op == OP_JAL) begin
            return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
        end else if (op == OP_BAD_OPC) begin
            // load opcode is outside the subset
            return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
        end
        // funct7 of a multiply
        return {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    // drive one strobe and queue the writeback the ISA rules give
    task automatic issue(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        wb_exp_t     e;
        a = shadow[rs1];
        b = (op < OP_ADDI) ? shadow[rs2] : {{20{imm[11]}}, imm[11:0]};
        case ((op < OP_LUI) ? op % 8 : op)
            0:       res = a + b;
            1:       res = a - b;
            2:       res = a & b;
            3:       res = a | b;
            4:       res = a ^ b;
            5:       res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       res = a << b[4:0];
            7:       res = a >> b[4:0];
            OP_LUI:  res = {imm[31:12], 12'b0};
            OP_JAL:  res = cur_pc + 32'd4;
            default: res = 32'd0;
        endcase
        e.pc       = cur_pc;
        e.data     = res;
        e.cyc      = cycles + 2;
        e.rd       = rd;
        e.wr       = (op <= OP_JAL) && (rd != 5'd0);
        e.chk_data = (op <= OP_JAL);
        exp_q.push_back(e);
        if (e.wr) begin
            shadow[rd] = res;
        end
        i_inst       = encode(op, rd, rs1, rs2, imm);
        i_pc         = cur_pc;
        i_inst_valid = 1'b1;
        cur_pc       = cur_pc + 32'd4;
        @(posedge i_sys_clk);
        #1;
        i_inst_valid = 1'b0;
    endtask

    // wait until every queued writeback has been seen
    task automatic drain();
        @(posedge i_sys_clk);
        while (exp_q.size() != 0) begin
            @(posedge i_sys_clk);
        end
        #1;
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (n_fail == fails_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, n_fail - fails_before);
        end
    endtask

    // ============================================================
    // tests
    // ============================================================
    task automatic idle_after_reset();
        int f0;
        f0 = n_fail;
        repeat (4) @(posedge i_sys_clk);
        #1;
        issue(OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd17);
        drain();
        report_test("idle_after_reset", f0);
    endtask

    task automatic imm_ops();
        int          f0;
        logic [31:0] r;
        f0 = n_fail;
        // x1..x15 get random values
        for (int i = 1; i < 16; i++) begin
            r = $random(seed);
            issue(OP_LUI, 5'(i), 5'd0, 5'd0, r);
            drain();
            issue(OP_ADDI, 5'(i), 5'(i), 5'd0, r);
            drain();
        end
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            // odd rounds use a negative immediate
            r[11] = i[0];
            issue((i % 5 == 0) ? OP_ADDI : 9 + i % 5, 5'(16 + r[15:12]),
                  5'(1 + r[19:16] % 15), 5'd0, r);
            drain();
        end
        report_test("imm_ops", f0);
    endtask

    task automatic reg_ops();
        int          f0;
        logic [31:0] r;
        f0 = n_fail;
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            issue(OP_ADD + i % 8, 5'(16 + r[3:0]), 5'(1 + r[7:4] % 15),
                  5'(1 + r[11:8] % 15), 32'd0);
            drain();
        end
        report_test("reg_ops", f0);
    endtask

    task automatic jal_and_x0();
        int f0;
        f0 = n_fail;
        issue(OP_JAL, 5'd5, 5'd0, 5'd0, 32'h0000_0100);
        drain();
        // negative offset with the link to x0 dropped
        issue(OP_JAL, 5'd0, 5'd0, 5'd0, 32'hffff_fff8);
        drain();
        issue(OP_ADD, 5'd16, 5'd0, 5'd0, 32'd0);
        drain();
        issue(OP_ADDI, 5'd17, 5'd5, 5'd0, 32'd0);
        drain();
        report_test("jal_and_x0", f0);
    endtask

    task automatic illegal_ops();
        int f0;
        f0 = n_fail;
        issue(OP_BAD_OPC, 5'd3, 5'd1, 5'd0, 32'h7ff);
        drain();
        issue(OP_BAD_F7, 5'd4, 5'd1, 5'd2, 32'd0);
        drain();
        // x3 and x4 still hold their old values
        issue(OP_ADDI, 5'd18, 5'd3, 5'd0, 32'd0);
        drain();
        issue(OP_ADDI, 5'd19, 5'd4, 5'd0, 32'd0);
        drain();
        report_test("illegal_ops", f0);
    endtask

    task automatic back_to_back();
        int          f0;
        logic [31:0] r;
        f0 = n_fail;
        // sources x1..x12 are not written in this burst
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            issue((i % 2 == 0) ? OP_ADD + i : OP_ADDI, 5'(24 + i), 5'(1 + i), 5'(7 + i), r);
        end
        drain();
        report_test("back_to_back", f0);
    endtask

    initial begin
        seed         = 32'h54ce_a4d6;
        cur_pc       = 32'h8000_0000;
        i_sys_rst_n  = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = 32'd0;
        i_pc         = 32'd0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = 32'd0;
        end
        repeat (5) @(posedge i_sys_clk);
        #1;
        i_sys_rst_n = 1'b1;
        idle_after_reset();
        imm_ops();
        reg_ops();
        jal_and_x0();
        illegal_ops();
        back_to_back();
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/core_pkg.sv
logic/idex_if.sv
logic/gpr_file.sv
logic/inst_decoder.sv
logic/idu2exu.sv
logic/alu_exec.sv
logic/core_top.sv
tests/core_props.sv
tests/tb_core_top.sv

/* Bender.yml */
package:
  name: core_slice

sources:
  - logic/core_pkg.sv
  - logic/idex_if.sv
  - logic/gpr_file.sv
  - logic/inst_decoder.sv
  - logic/idu2exu.sv
  - logic/alu_exec.sv
  - logic/core_top.sv
  - target: test
    files:
      - tests/core_props.sv
      - tests/tb_core_top.sv
